/* icache_top.f */
verilog/icache_pkg.sv
verilog/icache_ram.sv
verilog/icache_ctrl.sv
verilog/axi_read_master.sv
verilog/icache_top.sv
testbench/icache_checker.sv
testbench/tb_icache.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_icache
FILELIST ?= icache_top.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_icache.sv */
module tb_icache
	import icache_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int NUM_REQ = 600;
	localparam int FLUSH_EVERY = 150;
	localparam int MISS_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = NUM_REQ * MISS_CYCLES
		+ (NUM_REQ / FLUSH_EVERY + 1) * LINES + 500;

	logic i_clock;
	logic i_rst_n;
	logic i_req_valid;
	fetch_req_t i_req;
	logic o_req_ready;
	logic i_flush;
	logic o_resp_valid;
	fetch_resp_t o_resp;
	logic o_arvalid;
	axi_ar_t o_ar;
	logic i_arready;
	logic i_rvalid;
	axi_r_t i_r;
	logic o_rready;

	int errors;
	int checks;
	int pending;
	int misses;
	int cycles;
	logic [31:0] stim_rng;
	logic [31:0] bus_rng;
	logic [1:0] ar_wait;
	logic [1:0] r_wait;
	logic r_pending;
	logic [29:0] r_addr;

	icache_top i_dut (.*);

	icache_checker i_checker (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_req_valid(i_req_valid),
		.i_req(i_req),
		.i_req_ready(o_req_ready),
		.i_flush(i_flush),
		.i_resp_valid(o_resp_valid),
		.i_resp(o_resp),
		.i_arvalid(o_arvalid),
		.i_ar(o_ar),
		.i_arready(i_arready),
		.i_rvalid(i_rvalid),
		.i_rready(o_rready),
		.o_errors(errors),
		.o_checks(checks),
		.o_pending(pending),
		.o_misses(misses)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] scramble(input logic [29:0] addr);
		logic [31:0] x;
		x = {2'b00, addr} * 32'h9e37_79b1;
		return x ^ 32'h5a5a_1234;
	endfunction

	// A small hot pool, conflicting tags on the same indexes, the error
	// region and scattered addresses.
	function automatic logic [29:0] pick_addr(input logic [31:0] r);
		case (r[2:0])
			3'd0, 3'd1, 3'd2, 3'd3: return {24'd1, 3'd0, r[5:3]};
			3'd4: return {22'd0, r[9:8] | 2'd2, 3'd0, r[5:3]};
			3'd5: return {1'b1, 28'd0, r[3]};
			default: return {1'b0, r[31:3]};
		endcase
	endfunction

	task automatic send_req(input logic [29:0] addr);
		i_req_valid <= 1'b1;
		i_req <= '{addr: addr};
		@(posedge i_clock);
		while (!o_req_ready) begin
			@(posedge i_clock);
		end
	endtask

	// Idle means two ready edges in a row after valid dropped.
	task automatic wait_idle();
		int quiet;
		quiet = 0;
		while (quiet < 2) begin
			@(posedge i_clock);
			quiet = o_req_ready ? quiet + 1 : 0;
		end
	endtask

	initial begin
		i_clock = 1'b0;
		forever #20 i_clock = ~i_clock;
	end

	initial begin
		i_rst_n = 1'b0;
		i_req_valid = 1'b0;
		i_req = '0;
		i_flush = 1'b0;
		stim_rng = 32'hc0eb;
		repeat (4) @(posedge i_clock);
		i_rst_n <= 1'b1;
		for (int i = 0; i < NUM_REQ; i++) begin
			stim_rng = xorshift(stim_rng);
			if (stim_rng[31:30] == 2'd0) begin
				i_req_valid <= 1'b0;
				@(posedge i_clock);
			end
			send_req(pick_addr(stim_rng));
			if (i % FLUSH_EVERY == FLUSH_EVERY - 1) begin
				i_req_valid <= 1'b0;
				wait_idle();
				i_flush <= 1'b1;
				@(posedge i_clock);
				i_flush <= 1'b0;
			end
		end
		i_req_valid <= 1'b0;
		wait_idle();
		repeat (4) @(posedge i_clock);
		$display("checks %0d, misses %0d, unanswered %0d, errors %0d", checks, misses,
			pending, errors);
		if (errors == 0 && pending == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// AXI slave memory with random AR and R delays.
	initial begin
		i_arready = 1'b0;
		i_rvalid = 1'b0;
		i_r = '0;
		bus_rng = 32'hc0eb ^ 32'h1357_9bdf;
		ar_wait = 2'd0;
		r_wait = 2'd0;
		r_pending = 1'b0;
		r_addr = '0;
	end

	always @(posedge i_clock) begin
		bus_rng = xorshift(bus_rng);
		if (o_arvalid && i_arready) begin
			i_arready <= 1'b0;
			r_addr <= o_ar.addr[31:2];
			r_pending <= 1'b1;
			r_wait <= bus_rng[1:0];
			ar_wait <= bus_rng[3:2];
		end else if (o_arvalid) begin
			if (ar_wait == 2'd0) begin
				i_arready <= 1'b1;
			end else begin
				ar_wait <= ar_wait - 2'd1;
			end
		end
		if (i_rvalid && o_rready) begin
			i_rvalid <= 1'b0;
			r_pending <= 1'b0;
		end else if (r_pending && !i_rvalid) begin
			if (r_wait == 2'd0) begin
				i_rvalid <= 1'b1;
				if (r_addr[29]) begin
					i_r <= '{data: 32'h0, resp: 2'b10};
				end else begin
					i_r <= '{data: scramble(r_addr), resp: 2'b00};
				end
			end else begin
				r_wait <= r_wait - 2'd1;
			end
		end
	end

	always @(posedge i_clock) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("tests failed");
			$finish;
		end
	end

	initial cycles = 0;

endmodule

/* testbench/icache_checker.sv */
module icache_checker
	import icache_pkg::*;
(
	input logic i_clock,
	input logic i_rst_n,
	input logic i_req_valid,
	input fetch_req_t i_req,
	input logic i_req_ready,
	input logic i_flush,
	input logic i_resp_valid,
	input fetch_resp_t i_resp,
	input logic i_arvalid,
	input axi_ar_t i_ar,
	input logic i_arready,
	input logic i_rvalid,
	input logic i_rready,
	output int o_errors,
	output int o_checks,
	output int o_pending,
	output int o_misses
);
	timeunit 1ns;
	timeprecision 1ns;

	typedef struct packed {
		logic [29:0] addr;
		logic miss;
	} pending_t;

	logic line_valid [LINES];
	logic [TAG_BITS-1:0] line_tag [LINES];
	pending_t reqs [$];
	logic [29:0] exp_ar [$];
	logic sweep_active;
	logic r_open;
	int low_cycles;
	int errors;
	int checks;
	int misses;

	assign o_errors = errors;
	assign o_checks = checks;
	assign o_pending = reqs.size();
	assign o_misses = misses;

	// The memory returns a fixed scramble of the word address.
	function automatic logic [31:0] word_of(input logic [29:0] addr);
		logic [31:0] x;
		x = {2'b00, addr} * 32'h9e37_79b1;
		return x ^ 32'h5a5a_1234;
	endfunction

	task automatic clear_model();
		for (int i = 0; i < LINES; i++) begin
			line_valid[i] = 1'b0;
			line_tag[i] = '0;
		end
		sweep_active = 1'b1;
		low_cycles = 0;
	endtask

	initial begin
		errors = 0;
		checks = 0;
		misses = 0;
		r_open = 1'b0;
		clear_model();
	end

	always @(posedge i_clock) begin
		pending_t rec;
		logic [INDEX_BITS-1:0] idx;
		logic [31:0] exp_data;
		logic exp_err;
		if (!i_rst_n) begin
			clear_model();
			reqs.delete();
			exp_ar.delete();
			r_open = 1'b0;
		end else begin
			if (sweep_active) begin
				if (!i_req_ready) begin
					low_cycles++;
				end else begin
					if (low_cycles < LINES) begin
						$display("Error at %0t: ready rose after %0d sweep cycles", $time,
							low_cycles);
						errors++;
					end
					sweep_active = 1'b0;
				end
				if (i_arvalid || i_rready) begin
					$display("Error at %0t: AXI activity during clear sweep", $time);
					errors++;
				end
			end
			if (i_flush) begin
				clear_model();
			end
			if (i_rready && !r_open) begin
				$display("Error at %0t: rready high with no read outstanding", $time);
				errors++;
			end
			if (i_rvalid && i_rready) begin
				r_open = 1'b0;
			end
			if (i_arvalid && i_arready) begin
				checks++;
				r_open = 1'b1;
				if (exp_ar.size() == 0) begin
					$display("Error at %0t: unexpected AR to %h", $time, i_ar.addr);
					errors++;
				end else begin
					if (i_ar.addr != {exp_ar[0], 2'b00} || i_ar.prot != 3'b100) begin
						$display("Error at %0t: AR %h/%b, expected %h/100", $time,
							i_ar.addr, i_ar.prot, {exp_ar[0], 2'b00});
						errors++;
					end
					void'(exp_ar.pop_front());
				end
			end
			if (i_resp_valid) begin
				checks++;
				if (reqs.size() == 0) begin
					$display("Error at %0t: response without a request", $time);
					errors++;
				end else begin
					rec = reqs.pop_front();
					exp_err = rec.addr[29];
					exp_data = exp_err ? 32'h0 : word_of(rec.addr);
					if (i_resp.addr != rec.addr || i_resp.data != exp_data
						|| i_resp.err != exp_err) begin
						$display("Error at %0t: resp %h %h %b, expected %h %h %b", $time,
							i_resp.addr, i_resp.data, i_resp.err, rec.addr, exp_data,
							exp_err);
						errors++;
					end
					if (rec.miss && exp_ar.size() != 0) begin
						$display("Error at %0t: miss on %h answered without AR", $time,
							rec.addr);
						errors++;
						exp_ar.delete();
					end
					idx = rec.addr[INDEX_BITS-1:0];
					if (rec.miss && !exp_err) begin
						line_valid[idx] = 1'b1;
						line_tag[idx] = rec.addr[29:INDEX_BITS];
					end
				end
			end
			if (i_req_valid && i_req_ready) begin
				idx = i_req.addr[INDEX_BITS-1:0];
				rec.addr = i_req.addr;
				rec.miss = !line_valid[idx] || line_tag[idx] != i_req.addr[29:INDEX_BITS];
				if (rec.miss) begin
					exp_ar.push_back(i_req.addr);
					misses++;
				end
				reqs.push_back(rec);
			end
		end
	end

endmodule

/* verilog/icache_top.sv */
module icache_top
	import icache_pkg::*;
(
	input logic i_clock,
	input logic i_rst_n,
	input logic i_req_valid,
	input fetch_req_t i_req,
	output logic o_req_ready,
	input logic i_flush,
	output logic o_resp_valid,
	output fetch_resp_t o_resp,
	output logic o_arvalid,
	output axi_ar_t o_ar,
	input logic i_arready,
	input logic i_rvalid,
	input axi_r_t i_r,
	output logic o_rready
);

	logic [INDEX_BITS-1:0] ram_index;
	logic ram_write;
	cache_line_t ram_wline;
	cache_line_t ram_rline;
	logic refill_valid;
	refill_req_t refill;
	logic done;
	refill_rsp_t done_rsp;

	icache_ctrl u_ctrl (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_req_valid(i_req_valid),
		.i_req(i_req),
		.o_req_ready(o_req_ready),
		.i_flush(i_flush),
		.o_resp_valid(o_resp_valid),
		.o_resp(o_resp),
		.o_index(ram_index),
		.o_write(ram_write),
		.o_wline(ram_wline),
		.i_rline(ram_rline),
		.o_refill_valid(refill_valid),
		.o_refill(refill),
		.i_done(done),
		.i_done_rsp(done_rsp)
	);

	icache_ram u_ram (
		.i_clock(i_clock),
		.i_index(ram_index),
		.i_write(ram_write),
		.i_wline(ram_wline),
		.o_rline(ram_rline)
	);

	axi_read_master u_master (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_refill_valid(refill_valid),
		.i_refill(refill),
		.o_done(done),
		.o_done_rsp(done_rsp),
		.o_arvalid(o_arvalid),
		.o_ar(o_ar),
		.i_arready(i_arready),
		.i_rvalid(i_rvalid),
		.i_r(i_r),
		.o_rready(o_rready)
	);

endmodule

/* verilog/axi_read_master.sv */
module axi_read_master
	import icache_pkg::*;
(
	input logic i_clock,
	input logic i_rst_n,
	input logic i_refill_valid,
	input refill_req_t i_refill,
	output logic o_done,
	output refill_rsp_t o_done_rsp,
	output logic o_arvalid,
	output axi_ar_t o_ar,
	input logic i_arready,
	input logic i_rvalid,
	input axi_r_t i_r,
	output logic o_rready
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_ADDR,
		M_DATA
	} master_state_t;

	master_state_t state;
	logic [31:0] ar_addr;

	assign o_arvalid = (state == M_ADDR);
	assign o_rready = (state == M_DATA);
	assign o_ar = '{addr: ar_addr, prot: PROT_INSN};

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= M_IDLE;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				M_IDLE: begin
					if (i_refill_valid) begin
						state <= M_ADDR;
					end
				end
				M_ADDR: begin
					if (i_arready) begin
						state <= M_DATA;
					end
				end
				M_DATA: begin
					if (i_rvalid) begin
						o_done <= 1'b1;
						state <= M_IDLE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == M_IDLE && i_refill_valid) begin
			ar_addr <= {i_refill.addr, 2'b00};
		end
		// SLVERR and DECERR both count as a failed fetch.
		if (state == M_DATA && i_rvalid) begin
			o_done_rsp <= '{data: i_r.data, err: (i_r.resp != RESP_OKAY)};
		end
	end

	a_ar_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_arvalid && !i_arready |=> o_arvalid && $stable(o_ar));

	a_ar_r_exclusive: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!(o_arvalid && o_rready));

	// The controller must wait for done before it asks again.
	a_one_in_flight: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_refill_valid |-> state == M_IDLE);

endmodule

/* verilog/icache_ctrl.sv */
module icache_ctrl
	import icache_pkg::*;
(
	input logic i_clock,
	input logic i_rst_n,
	input logic i_req_valid,
	input fetch_req_t i_req,
	output logic o_req_ready,
	input logic i_flush,
	output logic o_resp_valid,
	output fetch_resp_t o_resp,
	output logic [INDEX_BITS-1:0] o_index,
	output logic o_write,
	output cache_line_t o_wline,
	input cache_line_t i_rline,
	output logic o_refill_valid,
	output refill_req_t o_refill,
	input logic i_done,
	input refill_rsp_t i_done_rsp
);

	ctrl_state_t state;
	logic [INDEX_BITS-1:0] clear_cnt;

	// The lookup slot holds the address whose line is on i_rline.
	logic slot_valid;
	logic [29:0] slot_addr;

	logic hit;
	logic miss;
	logic flush_go;
	logic accept;

	always_comb begin
		hit = slot_valid && i_rline.valid && (i_rline.tag == slot_addr[29:INDEX_BITS]);
		miss = slot_valid && !hit;
		flush_go = (state == ST_LOOKUP) && !slot_valid && i_flush;
		o_req_ready = (state == ST_LOOKUP) && !miss && !flush_go;
		accept = i_req_valid && o_req_ready;
	end

	// RAM port. During a refill the slot index is kept on the RAM so the
	// write in ST_RESPOND lands on the missed line.
	always_comb begin
		case (state)
			ST_CLEAR: o_index = clear_cnt;
			ST_LOOKUP: o_index = i_req.addr[INDEX_BITS-1:0];
			default: o_index = slot_addr[INDEX_BITS-1:0];
		endcase
		o_write = (state == ST_CLEAR) || (state == ST_RESPOND && !o_resp.err);
		if (state == ST_CLEAR) begin
			o_wline = '0;
		end else begin
			o_wline = '{valid: 1'b1, tag: slot_addr[29:INDEX_BITS], data: o_resp.data};
		end
	end

	assign o_refill = '{addr: slot_addr};

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_CLEAR;
			clear_cnt <= '0;
			slot_valid <= 1'b0;
			o_resp_valid <= 1'b0;
			o_refill_valid <= 1'b0;
		end else begin
			slot_valid <= accept;
			o_resp_valid <= 1'b0;
			o_refill_valid <= 1'b0;
			case (state)
				ST_CLEAR: begin
					clear_cnt <= clear_cnt + 1'b1;
					if (clear_cnt == INDEX_BITS'(LINES - 1)) begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					if (flush_go) begin
						state <= ST_CLEAR;
					end else if (miss) begin
						state <= ST_REFILL;
						o_refill_valid <= 1'b1;
					end else if (hit) begin
						o_resp_valid <= 1'b1;
					end
				end
				ST_REFILL: begin
					if (i_done) begin
						o_resp_valid <= 1'b1;
						state <= ST_RESPOND;
					end
				end
				ST_RESPOND: begin
					state <= ST_LOOKUP;
				end
				default: state <= ST_CLEAR;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			slot_addr <= i_req.addr;
		end
		if (state == ST_LOOKUP && hit) begin
			o_resp <= '{addr: slot_addr, data: i_rline.data, err: 1'b0};
		end else if (state == ST_REFILL && i_done) begin
			// The refilled word is held here and written to the RAM from o_resp.
			o_resp <= '{addr: slot_addr, data: i_done_rsp.data, err: i_done_rsp.err};
		end
	end

	// A hit response comes two edges after its request was taken.
	a_resp_after_accept: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_resp_valid && $past(state) == ST_LOOKUP |-> $past(accept, 2));

	a_refill_on_entry: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_refill_valid |-> state == ST_REFILL && $past(state) == ST_LOOKUP);

	a_no_error_write: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		state == ST_RESPOND && o_write |-> $past(i_done && !i_done_rsp.err));

endmodule

/* verilog/icache_ram.sv */
module icache_ram
	import icache_pkg::*;
(
	input logic i_clock,
	input logic [INDEX_BITS-1:0] i_index,
	input logic i_write,
	input cache_line_t i_wline,
	output cache_line_t o_rline
);

	cache_line_t mem [LINES];

	// The entry is read on every edge, so the line for an index presented
	// in one cycle is on o_rline during the next.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_index] <= i_wline;
		end
		o_rline <= mem[i_index];
	end

endmodule

/* verilog/icache_pkg.sv */
package icache_pkg;

	// Direct-mapped geometry with one 32-bit word per line.
	localparam int INDEX_BITS = 6;
	localparam int LINES = 1 << INDEX_BITS;
	localparam int TAG_BITS = 30 - INDEX_BITS;

	// Unprivileged, secure, instruction access.
	localparam logic [2:0] PROT_INSN = 3'b100;
	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef enum logic [1:0] {
		ST_CLEAR,
		ST_LOOKUP,
		ST_REFILL,
		ST_RESPOND
	} ctrl_state_t;

	typedef struct packed {
		logic [29:0] addr;
	} fetch_req_t;

	typedef struct packed {
		logic [29:0] addr;
		logic [31:0] data;
		logic err;
	} fetch_resp_t;

	typedef struct packed {
		logic valid;
		logic [TAG_BITS-1:0] tag;
		logic [31:0] data;
	} cache_line_t;

	typedef struct packed {
		logic [29:0] addr;
	} refill_req_t;

	typedef struct packed {
		logic [31:0] data;
		logic err;
	} refill_rsp_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [2:0] prot;
	} axi_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0] resp;
	} axi_r_t;

endpackage
